// File: Makefile
TOP = umode_monitor_tb

sim:
	verilator --binary --timing --assert -f sim.f --top-module $(TOP) -o simv
	./obj_dir/simv | tee /dev/stderr | grep -q "TESTS PASSED"

clean:
	rm -rf obj_dir

.PHONY: sim clean

// File: common/rvfi_pkg.sv
// --------------------------------------------------
// Retirement trace constants: privilege codes, the
// SYSTEM opcode, CSR addresses, MRET/DRET words,
// revoking causes and the CSR write-word union
// --------------------------------------------------

package rvfi_pkg;

  // Privilege codes, only U and M exist on this core
  localparam logic [1:0] MODE_U = 2'b00;
  localparam logic [1:0] MODE_M = 2'b11;

  localparam logic [6:0] OPC_SYSTEM = 7'b1110011;

  localparam logic [11:0] CSR_MSTATUS = 12'h300;
  localparam logic [11:0] CSR_DCSR    = 12'h7B0;

  // Full encodings, no operand fields
  localparam logic [31:0] INSN_MRET = 32'h3020_0073;
  localparam logic [31:0] INSN_DRET = 32'h7b20_0073;

  // Causes that revoke a retirement
  localparam logic [5:0] CAUSE_ACCESS_FAULT = 6'd1;
  localparam logic [5:0] CAUSE_BUS_FAULT    = 6'd24;

  typedef struct packed {
    logic [31:18] rsvd_hi;
    logic         mprv;
    logic [16:13] rsvd_mid;
    logic [12:11] mpp;
    logic [10:0]  rsvd_lo;
  } mstatus_view_t;

  typedef struct packed {
    logic [31:2] rsvd;
    logic [1:0]  prv;
  } dcsr_view_t;

  // Same rs1 word, decoded by the CSR it targets
  typedef union packed {
    mstatus_view_t mstatus;
    dcsr_view_t    dcsr;
  } csr_word_u;

endpackage

// File: common/umode_evt_pkg.sv
// --------------------------------------------------
// Event bit positions of the record mask and the
// counter bank layout
// --------------------------------------------------

package umode_evt_pkg;

  localparam int NUM_EVT = 8;

  // Bit order of the event mask
  localparam int EVT_CSR_READ      = 0;
  localparam int EVT_CSR_WRITE     = 1;
  localparam int EVT_MPP_WRITE     = 2;
  localparam int EVT_MRET          = 3;
  localparam int EVT_DRET          = 4;
  localparam int EVT_UMODE         = 5;
  localparam int EVT_PRV_WRITE     = 6;
  // Added by the tracker, not by decode
  localparam int EVT_MODE_MISMATCH = 7;

  // One counter per event, plus the drop counter on top
  localparam int CNT_DROP = 8;
  localparam int NUM_CNT  = 9;

  // Wide enough for NUM_CNT, upper codes read as zero
  localparam int CNT_SEL_W = 4;

endpackage

// File: hw/event_counters.sv
// --------------------------------------------------
// Saturating counters, one per event plus drops,
// with a selectable read port
// --------------------------------------------------

module event_counters
  import umode_evt_pkg::*;
#(
  parameter int COUNT_W = 16
) (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  logic                 evt_valid,
  input  logic [NUM_EVT-1:0]   evt_mask,
  input  logic                 drop_pulse,
  input  logic [CNT_SEL_W-1:0] cnt_sel,
  output logic [COUNT_W-1:0]   cnt_value
);

  logic [COUNT_W-1:0] cnt_q [NUM_CNT];
  logic [NUM_CNT-1:0] inc;

  always_comb begin
    inc = '0;
    for (int i = 0; i < NUM_EVT; i++) begin
      inc[i] = evt_valid && evt_mask[i];
    end
    inc[CNT_DROP] = drop_pulse;
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      for (int i = 0; i < NUM_CNT; i++) begin
        cnt_q[i] <= '0;
      end
    end else begin
      for (int i = 0; i < NUM_CNT; i++) begin
        // Hold at all ones
        if (inc[i] && (cnt_q[i] != {COUNT_W{1'b1}})) begin
          cnt_q[i] <= cnt_q[i] + 1'b1;
        end
      end
    end
  end

  // Unused select codes read as zero
  assign cnt_value = (cnt_sel < CNT_SEL_W'(NUM_CNT)) ? cnt_q[cnt_sel] : '0;

endmodule

// File: hw/mode_tracker.sv
// --------------------------------------------------
// Return-mode tracker: MPP write, then MRET, then
// compare the next retirement's mode with MPP
// --------------------------------------------------

module mode_tracker
  import rvfi_pkg::*;
(
  input  logic       clk_i,
  input  logic       rst_ni,
  input  logic       evt_valid,
  input  logic       evt_mpp_wr,
  input  logic [1:0] evt_mpp,
  input  logic       evt_mret,
  input  logic [1:0] evt_mode,
  output logic       mismatch
);

  localparam logic [1:0] ST_IDLE     = 2'd0;
  localparam logic [1:0] ST_ARMED    = 2'd1;
  localparam logic [1:0] ST_RETURNED = 2'd2;

  logic [1:0] state_q;
  logic [1:0] state_d;
  logic [1:0] exp_mode_q;
  logic [1:0] mpp_mode;

  // Only U and M exist, any other MPP lands in M
  assign mpp_mode = (evt_mpp == MODE_U) ? MODE_U : MODE_M;

  // First retirement after the MRET
  assign mismatch = evt_valid && (state_q == ST_RETURNED) && (evt_mode != exp_mode_q);

  always_comb begin
    state_d = state_q;
    if (evt_valid) begin
      case (state_q)
        ST_IDLE: begin
          if (evt_mpp_wr) begin
            state_d = ST_ARMED;
          end
        end
        ST_ARMED: begin
          if (evt_mret) begin
            state_d = ST_RETURNED;
          end else if (evt_mpp_wr) begin
            // A fresh MPP write re-arms with the new value
            state_d = ST_ARMED;
          end else begin
            state_d = ST_IDLE;
          end
        end
        ST_RETURNED: begin
          state_d = evt_mpp_wr ? ST_ARMED : ST_IDLE;
        end
        default: begin
          state_d = ST_IDLE;
        end
      endcase
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= ST_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // Expected mode follows every MPP write
  always_ff @(posedge clk_i) begin
    if (evt_valid && evt_mpp_wr) begin
      exp_mode_q <= mpp_mode;
    end
  end

endmodule

// File: hw/report_queue.sv
// --------------------------------------------------
// Record FIFO with credit-based output; records
// arriving at a full queue are dropped
// --------------------------------------------------

module report_queue
  import umode_evt_pkg::*;
#(
  parameter int QUEUE_DEPTH = 4,
  parameter int CREDITS     = 2
) (
  input  logic               clk_i,
  input  logic               rst_ni,
  input  logic               evt_valid,
  input  logic [NUM_EVT-1:0] evt_mask,
  input  logic [1:0]         evt_mode,
  input  logic               rpt_credit,
  output logic               rpt_valid,
  output logic [NUM_EVT-1:0] rpt_evt,
  output logic [1:0]         rpt_mode,
  output logic               drop_pulse
);

  localparam int PTR_W  = (QUEUE_DEPTH > 1) ? $clog2(QUEUE_DEPTH) : 1;
  localparam int CNT_W  = $clog2(QUEUE_DEPTH + 1);
  // One spare code so an extra returned credit is not lost to wrap
  localparam int CRED_W = $clog2(CREDITS + 2);
  localparam int REC_W  = NUM_EVT + 2;

  logic [REC_W-1:0]  mem [QUEUE_DEPTH];
  logic [PTR_W-1:0]  wr_ptr_q;
  logic [PTR_W-1:0]  rd_ptr_q;
  logic [CNT_W-1:0]  count_q;
  logic [CRED_W-1:0] credit_q;
  logic              full;
  logic              empty;
  logic              push;
  logic              pop;

  assign full  = (count_q == CNT_W'(QUEUE_DEPTH));
  assign empty = (count_q == '0);

  // Records with no event are not reported
  assign push       = evt_valid && (evt_mask != '0) && !full;
  assign drop_pulse = evt_valid && (evt_mask != '0) && full;

  assign pop       = !empty && (credit_q != '0);
  assign rpt_valid = pop;
  assign rpt_evt   = mem[rd_ptr_q][NUM_EVT-1:0];
  assign rpt_mode  = mem[rd_ptr_q][REC_W-1:NUM_EVT];

  always_ff @(posedge clk_i) begin
    if (push) begin
      mem[wr_ptr_q] <= {evt_mode, evt_mask};
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
      credit_q <= CRED_W'(CREDITS);
    end else begin
      if (push) begin
        wr_ptr_q <= (wr_ptr_q == PTR_W'(QUEUE_DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (pop) begin
        rd_ptr_q <= (rd_ptr_q == PTR_W'(QUEUE_DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      if (push && !pop) begin
        count_q <= count_q + 1'b1;
      end else if (pop && !push) begin
        count_q <= count_q - 1'b1;
      end
      // Send and credit return may coincide
      if (pop && !rpt_credit) begin
        credit_q <= credit_q - 1'b1;
      end else if (rpt_credit && !pop) begin
        credit_q <= credit_q + 1'b1;
      end
    end
  end

endmodule

// File: hw/rvfi_decode.sv
// --------------------------------------------------
// Retirement decoder: drops revoked retirements,
// classifies the rest and registers the event mask
// --------------------------------------------------

module rvfi_decode
  import rvfi_pkg::*;
  import umode_evt_pkg::*;
(
  input  logic               clk_i,
  input  logic               rst_ni,
  input  logic               rvfi_valid,
  input  logic               rvfi_trap,
  input  logic [5:0]         rvfi_exc_cause,
  input  logic [31:0]        rvfi_insn,
  input  logic [31:0]        rvfi_rs1_rdata,
  input  logic [4:0]         rvfi_rd_addr,
  input  logic [1:0]         rvfi_mode,
  output logic               evt_valid,
  output logic [NUM_EVT-2:0] evt_mask,
  output logic [1:0]         evt_mode,
  output logic               evt_mpp_wr,
  output logic [1:0]         evt_mpp,
  output logic               evt_mret
);

  logic [6:0]         opcode;
  logic [2:0]         funct3;
  logic [4:0]         rs1_field;
  logic [11:0]        csr_addr;
  csr_word_u          wdata;
  logic               revoked;
  logic               valid_kept;
  logic               notrap;
  logic               is_csrrw_any;
  logic               is_csr;
  logic               csrrw_notrap;
  logic               mpp_wr;
  logic               mret;
  logic [NUM_EVT-2:0] mask_d;

  assign opcode    = rvfi_insn[6:0];
  assign funct3    = rvfi_insn[14:12];
  assign rs1_field = rvfi_insn[19:15];
  assign csr_addr  = rvfi_insn[31:20];
  assign wdata     = rvfi_rs1_rdata;

  // Access and bus faults take the retirement back
  assign revoked = rvfi_trap &&
                   (rvfi_exc_cause inside {CAUSE_ACCESS_FAULT, CAUSE_BUS_FAULT});
  assign valid_kept = rvfi_valid && !revoked;
  assign notrap     = valid_kept && !rvfi_trap;

  assign is_csrrw_any = funct3 inside {3'd1, 3'd5};
  assign is_csr = notrap && (opcode == OPC_SYSTEM) &&
                  (funct3 inside {3'd1, 3'd2, 3'd3, 3'd5, 3'd6, 3'd7});

  assign csrrw_notrap = notrap && (opcode == OPC_SYSTEM) && (funct3 == 3'd1);
  assign mpp_wr       = csrrw_notrap && (csr_addr == CSR_MSTATUS);
  assign mret         = notrap && (rvfi_insn == INSN_MRET);

  always_comb begin
    mask_d = '0;
    // csrrw/csrrwi with rd = x0 skip the read
    mask_d[EVT_CSR_READ]  = is_csr && ((rvfi_rd_addr != 5'd0) || !is_csrrw_any);
    // Set/clear forms with rs1 = x0 or uimm = 0 skip the write
    mask_d[EVT_CSR_WRITE] = is_csr && ((rs1_field != 5'd0) || is_csrrw_any);
    mask_d[EVT_MPP_WRITE] = mpp_wr;
    mask_d[EVT_MRET]      = mret;
    mask_d[EVT_DRET]      = notrap && (rvfi_insn == INSN_DRET);
    mask_d[EVT_UMODE]     = notrap && (rvfi_mode == MODE_U);
    mask_d[EVT_PRV_WRITE] = csrrw_notrap && (csr_addr == CSR_DCSR) &&
                            (wdata.dcsr.prv == MODE_U);
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      evt_valid  <= 1'b0;
      evt_mask   <= '0;
      evt_mpp_wr <= 1'b0;
      evt_mret   <= 1'b0;
    end else begin
      evt_valid  <= valid_kept;
      evt_mask   <= mask_d;
      evt_mpp_wr <= mpp_wr;
      evt_mret   <= mret;
    end
  end

  // Payload, only meaningful next to evt_valid
  always_ff @(posedge clk_i) begin
    if (valid_kept) begin
      evt_mode <= rvfi_mode;
      evt_mpp  <= wdata.mstatus.mpp;
    end
  end

endmodule

// File: hw/umode_monitor_top.sv
// --------------------------------------------------
// Monitor top: decode, mode tracker, counters and
// report queue
// --------------------------------------------------

module umode_monitor_top
  import umode_evt_pkg::*;
#(
  parameter int COUNT_W     = 16,
  parameter int QUEUE_DEPTH = 4,
  parameter int CREDITS     = 2
) (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  logic                 rvfi_valid,
  input  logic                 rvfi_trap,
  input  logic [5:0]           rvfi_exc_cause,
  input  logic [31:0]          rvfi_insn,
  input  logic [31:0]          rvfi_rs1_rdata,
  input  logic [4:0]           rvfi_rd_addr,
  input  logic [1:0]           rvfi_mode,
  input  logic                 rpt_credit,
  input  logic [CNT_SEL_W-1:0] cnt_sel,
  output logic                 rpt_valid,
  output logic [NUM_EVT-1:0]   rpt_evt,
  output logic [1:0]           rpt_mode,
  output logic [COUNT_W-1:0]   cnt_value
);

  logic               evt_valid;
  logic [NUM_EVT-2:0] evt_mask;
  logic [1:0]         evt_mode;
  logic               evt_mpp_wr;
  logic [1:0]         evt_mpp;
  logic               evt_mret;
  logic               mismatch;
  logic               drop_pulse;
  logic [NUM_EVT-1:0] evt_mask_full;

  // Mismatch is the top bit of the mask
  assign evt_mask_full = {mismatch, evt_mask};

  rvfi_decode u_decode (
    .clk_i, .rst_ni,
    .rvfi_valid, .rvfi_trap, .rvfi_exc_cause, .rvfi_insn,
    .rvfi_rs1_rdata, .rvfi_rd_addr, .rvfi_mode,
    .evt_valid, .evt_mask, .evt_mode, .evt_mpp_wr, .evt_mpp, .evt_mret
  );

  mode_tracker u_tracker (
    .clk_i, .rst_ni,
    .evt_valid, .evt_mpp_wr, .evt_mpp, .evt_mret, .evt_mode,
    .mismatch
  );

  event_counters #(.COUNT_W(COUNT_W)) u_counters (
    .clk_i, .rst_ni,
    .evt_valid, .evt_mask(evt_mask_full), .drop_pulse, .cnt_sel,
    .cnt_value
  );

  report_queue #(.QUEUE_DEPTH(QUEUE_DEPTH), .CREDITS(CREDITS)) u_queue (
    .clk_i, .rst_ni,
    .evt_valid, .evt_mask(evt_mask_full), .evt_mode, .rpt_credit,
    .rpt_valid, .rpt_evt, .rpt_mode, .drop_pulse
  );

endmodule

// File: sim.f
common/rvfi_pkg.sv
common/umode_evt_pkg.sv
hw/rvfi_decode.sv
hw/mode_tracker.sv
hw/event_counters.sv
hw/report_queue.sv
hw/umode_monitor_top.sv
verif/umode_monitor_asserts.sv
verif/umode_monitor_tb.sv

// File: verif/umode_monitor_asserts.sv
// --------------------------------------------------
// Concurrent checks on the report queue: credit
// use, credit bound and pushes into a full FIFO
// --------------------------------------------------

module umode_monitor_asserts #(
  parameter int CREDITS = 2,
  parameter int CRED_W  = 2,
  parameter int PTR_W   = 2
) (
  input logic              clk_i,
  input logic              rst_ni,
  input logic              rpt_valid,
  input logic              rpt_credit,
  input logic [CRED_W-1:0] credit_q,
  input logic              full,
  input logic [PTR_W-1:0]  wr_ptr_q
);
  timeunit 1ns;
  timeprecision 100ps;

  // Credit as the consumer sees it, one per send and one back per return
  int consumer_credit;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      consumer_credit <= CREDITS;
    end else begin
      consumer_credit <= consumer_credit - int'(rpt_valid) + int'(rpt_credit);
    end
  end

  // A record goes out only against a credit
  a_send_needs_credit : assert property (@(posedge clk_i) disable iff (!rst_ni)
    rpt_valid |-> (consumer_credit > 0))
    else $error("record sent while no credit was left");

  a_credit_bound : assert property (@(posedge clk_i) disable iff (!rst_ni)
    credit_q <= CRED_W'(CREDITS))
    else $error("credit count rose above its initial value");

  // Write pointer stays put while the queue is full
  a_no_push_full : assert property (@(posedge clk_i) disable iff (!rst_ni)
    full |=> $stable(wr_ptr_q))
    else $error("record pushed into a full queue");

endmodule

bind report_queue umode_monitor_asserts #(
  .CREDITS(CREDITS), .CRED_W(CRED_W), .PTR_W(PTR_W)
) u_asserts (
  .clk_i, .rst_ni, .rpt_valid, .rpt_credit, .credit_q, .full, .wr_ptr_q
);

// File: verif/umode_monitor_tb.sv
// --------------------------------------------------
// Monitor testbench: clock, trace stimulus, event
// model, record comparison and counter checks
// --------------------------------------------------

module umode_monitor_tb
  import umode_evt_pkg::*;
;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int COUNT_W     = 16;
  localparam int QUEUE_DEPTH = 4;
  localparam int CREDITS     = 2;
  localparam logic [31:0] NOP = 32'h0000_0013;

  logic clk_i, rst_ni, rvfi_valid, rvfi_trap, rpt_credit, rpt_valid;
  logic [5:0]           rvfi_exc_cause;
  logic [31:0]          rvfi_insn, rvfi_rs1_rdata;
  logic [4:0]           rvfi_rd_addr;
  logic [1:0]           rvfi_mode, rpt_mode;
  logic [CNT_SEL_W-1:0] cnt_sel;
  logic [NUM_EVT-1:0]   rpt_evt;
  logic [COUNT_W-1:0]   cnt_value;

  logic [9:0] exp_q [$];
  int         ev_count [NUM_CNT];
  int         seed = 37308;
  int         owed = 0;
  int         m_state = 0;
  logic [1:0] m_exp = 2'b11;
  logic       credit_en = 1'b1;
  logic       bp_mode = 1'b0;
  int         bp_count = 0;
  string      cur_test = "reset";

  umode_monitor_top #(.COUNT_W(COUNT_W), .QUEUE_DEPTH(QUEUE_DEPTH), .CREDITS(CREDITS)) DUT (
    .clk_i, .rst_ni, .rvfi_valid, .rvfi_trap, .rvfi_exc_cause, .rvfi_insn,
    .rvfi_rs1_rdata, .rvfi_rd_addr, .rvfi_mode, .rpt_credit, .cnt_sel,
    .rpt_valid, .rpt_evt, .rpt_mode, .cnt_value
  );

  initial begin
    clk_i = 1'b0;
    forever #20 clk_i = ~clk_i;
  end

  task automatic stop_run(input string msg);
    $display("TESTS FAILED");
    $fatal(1, "%s", msg);
  endtask

  task automatic check_value(input string label, input logic [31:0] exp, input logic [31:0] act);
    if (exp !== act) begin
      $display("MISMATCH %s %s: expected %h, actual %h", cur_test, label, exp, act);
      stop_run("value mismatch");
    end
  endtask

  // Expected event mask from the Zicsr and return-mode rules
  function automatic logic [7:0] umode_ref(input logic trap, input logic [31:0] insn,
                                           input logic [31:0] rs1, input logic [4:0] rd,
                                           input logic [1:0] mode, input int st,
                                           input logic [1:0] exp_mode);
    logic [7:0] m;
    logic       sys, csr_ins, rw;
    m = '0;
    sys = !trap && (insn[6:0] == 7'h73);
    csr_ins = sys && (insn[14:12] != 3'd0) && (insn[14:12] != 3'd4);
    rw = (insn[14:12] == 3'd1) || (insn[14:12] == 3'd5);
    m[EVT_CSR_READ]  = csr_ins && ((rd != 5'd0) || !rw);
    m[EVT_CSR_WRITE] = csr_ins && ((insn[19:15] != 5'd0) || rw);
    m[EVT_MPP_WRITE] = sys && (insn[14:12] == 3'd1) && (insn[31:20] == 12'h300);
    m[EVT_MRET]      = !trap && (insn == 32'h3020_0073);
    m[EVT_DRET]      = !trap && (insn == 32'h7b20_0073);
    m[EVT_UMODE]     = !trap && (mode == 2'b00);
    m[EVT_PRV_WRITE] = sys && (insn[14:12] == 3'd1) && (insn[31:20] == 12'h7b0) &&
                       (rs1[1:0] == 2'b00);
    m[EVT_MODE_MISMATCH] = (st == 2) && (mode != exp_mode);
    return m;
  endfunction

  function automatic logic [31:0] csr_insn(input logic [11:0] csr, input logic [4:0] rs1f,
                                           input logic [2:0] f3, input logic [4:0] rd);
    return {csr, rs1f, f3, rd, 7'h73};
  endfunction

  task automatic wait_room();
    int t;
    t = 0;
    while (exp_q.size() > 1 && t < 100) begin
      @(posedge clk_i);
      #2;
      t++;
    end
    if (exp_q.size() > 1) stop_run("timeout waiting for records to leave the queue");
  endtask

  task automatic wait_drain();
    int t;
    t = 0;
    while ((exp_q.size() != 0 || owed != 0) && t < 400) begin
      @(posedge clk_i);
      #2;
      t++;
    end
    if (exp_q.size() != 0) stop_run("timeout, expected records never arrived");
    if (owed != 0) stop_run("timeout, credits were never returned");
    repeat (3) @(posedge clk_i);
    #2;
  endtask

  task automatic retire(input logic trap, input logic [5:0] cause, input logic [31:0] insn,
                        input logic [31:0] rs1, input logic [4:0] rd, input logic [1:0] mode);
    logic [7:0] m;
    if (!bp_mode) wait_room();
    rvfi_valid = 1'b1;
    rvfi_trap = trap;
    rvfi_exc_cause = cause;
    rvfi_insn = insn;
    rvfi_rs1_rdata = rs1;
    rvfi_rd_addr = rd;
    rvfi_mode = mode;
    // Access and bus faults are invisible to the model
    if (!(trap && (cause == 6'd1 || cause == 6'd24))) begin
      m = umode_ref(trap, insn, rs1, rd, mode, m_state, m_exp);
      for (int i = 0; i < NUM_EVT; i++) ev_count[i] += int'(m[i]);
      if (m != '0) begin
        if (bp_mode && bp_count >= CREDITS + QUEUE_DEPTH) ev_count[CNT_DROP]++;
        else exp_q.push_back({mode, m});
        if (bp_mode) bp_count++;
      end
      if (m_state == 1 && m[EVT_MRET]) m_state = 2;
      else m_state = m[EVT_MPP_WRITE] ? 1 : 0;
      if (m[EVT_MPP_WRITE]) m_exp = (rs1[12:11] == 2'b00) ? 2'b00 : 2'b11;
    end
    @(posedge clk_i);
    #2;
    rvfi_valid = 1'b0;
  endtask

  task automatic check_counters();
    for (int i = 0; i < NUM_CNT; i++) begin
      cnt_sel = CNT_SEL_W'(i);
      @(negedge clk_i);
      check_value($sformatf("counter %0d", i), 32'(ev_count[i]), 32'(cnt_value));
      @(posedge clk_i);
      #2;
    end
    cnt_sel = CNT_SEL_W'(12);
    @(negedge clk_i);
    check_value("unused counter select", 32'd0, 32'(cnt_value));
    @(posedge clk_i);
    #2;
  endtask

  // Compare every record against the model
  initial begin
    logic [9:0] rec;
    forever begin
      @(negedge clk_i);
      if (rpt_valid === 1'b1) begin
        if (exp_q.size() == 0) stop_run("a record arrived when none was expected");
        rec = exp_q.pop_front();
        check_value("rpt_evt", 32'(rec[7:0]), 32'(rpt_evt));
        check_value("rpt_mode", 32'(rec[9:8]), 32'(rpt_mode));
        owed++;
      end
    end
  end

  // Return credits after a short random delay
  initial begin
    int delay;
    delay = 0;
    rpt_credit = 1'b0;
    forever begin
      @(posedge clk_i);
      #2;
      rpt_credit = 1'b0;
      if (credit_en && owed > 0) begin
        if (delay == 0) begin
          rpt_credit = 1'b1;
          owed--;
          delay = $random(seed) & 3;
        end else begin
          delay--;
        end
      end
    end
  end

  initial begin
    int r, f3, cause_i;
    logic [11:0] csr;
    rst_ni = 1'b0;
    rvfi_valid = 1'b0;
    rvfi_trap = 1'b0;
    rvfi_exc_cause = '0;
    rvfi_insn = NOP;
    rvfi_rs1_rdata = '0;
    rvfi_rd_addr = '0;
    rvfi_mode = 2'b11;
    cnt_sel = '0;
    for (int i = 0; i < NUM_CNT; i++) ev_count[i] = 0;
    repeat (2) @(posedge clk_i);
    #2;
    rst_ni = 1'b1;
    check_counters();

    cur_test = "csr_classify";
    for (int f = 0; f < 8; f++) begin
      for (int k = 0; k < 4; k++) begin
        retire(1'b0, 6'd0, csr_insn(12'h340, (k & 1) != 0 ? 5'd7 : 5'd0, 3'(f),
               (k & 2) != 0 ? 5'd5 : 5'd0), 32'h0, (k & 2) != 0 ? 5'd5 : 5'd0, 2'b11);
      end
    end
    retire(1'b1, 6'd2, csr_insn(12'h340, 5'd7, 3'd2, 5'd5), 32'h0, 5'd5, 2'b11);
    wait_drain();

    cur_test = "revoked";
    retire(1'b1, 6'd1, csr_insn(12'h300, 5'd3, 3'd1, 5'd4), 32'h0, 5'd4, 2'b00);
    retire(1'b1, 6'd24, 32'h3020_0073, 32'h0, 5'd0, 2'b00);
    wait_drain();
    check_counters();

    cur_test = "mpp_return";
    retire(1'b0, 6'd0, csr_insn(12'h300, 5'd1, 3'd1, 5'd0), 32'h0000_0000, 5'd0, 2'b11);
    retire(1'b0, 6'd0, 32'h3020_0073, 32'h0, 5'd0, 2'b11);
    retire(1'b0, 6'd0, NOP, 32'h0, 5'd0, 2'b00);
    retire(1'b0, 6'd0, csr_insn(12'h300, 5'd1, 3'd1, 5'd0), 32'h0000_0000, 5'd0, 2'b11);
    retire(1'b0, 6'd0, 32'h3020_0073, 32'h0, 5'd0, 2'b11);
    retire(1'b0, 6'd0, NOP, 32'h0, 5'd0, 2'b11);
    retire(1'b0, 6'd0, csr_insn(12'h300, 5'd1, 3'd1, 5'd0), 32'h0000_1800, 5'd0, 2'b11);
    retire(1'b0, 6'd0, NOP, 32'h0, 5'd0, 2'b11);
    retire(1'b0, 6'd0, 32'h3020_0073, 32'h0, 5'd0, 2'b11);
    retire(1'b0, 6'd0, NOP, 32'h0, 5'd0, 2'b00);
    wait_drain();

    cur_test = "dret_prv_umode";
    retire(1'b0, 6'd0, 32'h7b20_0073, 32'h0, 5'd0, 2'b11);
    retire(1'b0, 6'd0, csr_insn(12'h7b0, 5'd2, 3'd1, 5'd0), 32'h0000_0000, 5'd0, 2'b11);
    retire(1'b0, 6'd0, csr_insn(12'h7b0, 5'd2, 3'd1, 5'd0), 32'h0000_0003, 5'd0, 2'b11);
    retire(1'b0, 6'd0, NOP, 32'h0, 5'd0, 2'b00);
    wait_drain();

    cur_test = "back_pressure";
    credit_en = 1'b0;
    bp_mode = 1'b1;
    bp_count = 0;
    for (int i = 0; i < CREDITS + QUEUE_DEPTH + 2; i++) begin
      // Records differ so that dropping the wrong ones breaks the order
      retire(1'b0, 6'd0,
             ((i & 2) != 0) ? 32'h7b20_0073 :
                              csr_insn(12'h340, ((i & 4) != 0) ? 5'd3 : 5'd0, 3'd2, 5'd1),
             32'h0, 5'd1, ((i & 1) != 0) ? 2'b00 : 2'b11);
    end
    repeat (4) @(posedge clk_i);
    #2;
    bp_mode = 1'b0;
    credit_en = 1'b1;
    wait_drain();
    cnt_sel = CNT_SEL_W'(CNT_DROP);
    @(negedge clk_i);
    check_value("drop counter", 32'(ev_count[CNT_DROP]), 32'(cnt_value));
    @(posedge clk_i);
    #2;

    cur_test = "random_mix";
    for (int n = 0; n < 200; n++) begin
      r = $random(seed) & 7;
      f3 = $random(seed) & 7;
      cause_i = $random(seed) & 3;
      csr = ((r & 1) != 0) ? 12'h300 : (((r & 2) != 0) ? 12'h7b0 : 12'h340);
      rvfi_insn = (r < 4) ? csr_insn(csr, 5'($random(seed)), 3'(f3), 5'($random(seed))) :
                  (r == 4) ? 32'h3020_0073 : (r == 5) ? 32'h7b20_0073 :
                  (r == 6) ? NOP : csr_insn(12'h300, 5'd1, 3'd1, 5'd0);
      retire((($random(seed) & 7) == 0), (cause_i == 0) ? 6'd1 : (cause_i == 1) ? 6'd24 :
             6'd2, rvfi_insn, 32'($random(seed)), 5'($random(seed)),
             (($random(seed) & 1) != 0) ? 2'b11 : 2'b00);
    end
    wait_drain();
    check_counters();

    $display("TESTS PASSED");
    $finish;
  end

endmodule
